// ==== src/tft_params.svh ====
`ifndef TFT_PARAMS_SVH
`define TFT_PARAMS_SVH

// ***************************************************************************
// link depths
// ***************************************************************************

// command queue depth in execute, starting credits in decode.
`define TFT_CMD_CREDITS 4

// byte buffer depth in the bus writer, starting credits in execute.
`define TFT_BYTE_CREDITS 2

// ***************************************************************************
// sequencing
// ***************************************************************************

// pixels written per fill or clear.
`define TFT_FILL_PIXELS 8

// clk cycles per reset sequencer step.
`define TFT_RESET_PRESCALE 4

`endif

// ==== src/tft_pkg.sv ====
package tft_pkg;

    typedef logic [7:0]  tft_byte_t;    // one bus byte.
    typedef logic [15:0] pixel_t;       // rgb565.
    typedef logic [1:0]  colour_idx_t;  // red, green, blue, white.

    // codes sent to the panel controller.
    typedef tft_byte_t lcd_cmd_t;

    // opcodes on the decode to execute link.
    typedef enum logic [2:0] {
        SET_COLOUR,
        FILL,
        DISP_ON,
        DISP_OFF,
        CLEAR
    } cmd_op_t;

    // sequencer states, also brought out on tftstate.
    typedef enum logic [2:0] {
        INIT,
        IDLE,
        WAIT_TE,
        SEND_CMD,
        SEND_PIX
    } exec_state_t;

endpackage

// ==== src/reset_on_start.sv ====
`timescale 1ns/1ns
`include "tft_params.svh"

module reset_on_start (
    input  logic clk,
    input  logic manual,
    output logic reset
);

    localparam int PRESCALE = `TFT_RESET_PRESCALE;
    localparam int PW       = $clog2(PRESCALE);

    logic [PW-1:0] pre_cnt = '0;
    logic [2:0]    startup = 3'd4;      // power-on value, reset held.
    logic          tick;

    assign tick  = (pre_cnt == PW'(PRESCALE - 1));
    assign reset = startup[2] | manual; // msb is the reset.

    always_ff @(posedge clk or posedge manual) begin
        if (manual) begin
            pre_cnt <= '0;
            startup <= 3'd4;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                case (startup)
                    3'd4:    startup <= 3'd5;
                    3'd5:    startup <= 3'd6;
                    3'd6:    startup <= 3'd7;
                    3'd7:    startup <= 3'd0; // release.
                    default: startup <= startup;
                endcase
            end
        end
    end

endmodule

// ==== src/key_decode.sv ====
`timescale 1ns/1ns
`include "tft_params.svh"

module key_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic [7:0]           buttons,
    input  logic                 cmd_credit,
    output logic                 cmd_valid,
    output tft_pkg::cmd_op_t     cmd_op,
    output tft_pkg::colour_idx_t cmd_arg
);

    import tft_pkg::*;

    localparam int CMD_CREDITS = `TFT_CMD_CREDITS;
    localparam int CW          = $clog2(CMD_CREDITS + 1);

    logic [7:0]    sync_meta;
    logic [7:0]    sync_q;
    logic [7:0]    sync_prev;
    logic [7:0]    rise;
    logic [7:0]    pending;
    logic [7:0]    sel_mask;
    logic [2:0]    sel_idx;
    logic          have;
    logic [CW-1:0] credits;

    // ***********************************************************************
    // synchronizer and edge detect
    // ***********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_meta <= '0;
            sync_q    <= '0;
            sync_prev <= '0;
        end else begin
            sync_meta <= buttons;
            sync_q    <= sync_meta;
            sync_prev <= sync_q;
        end
    end

    assign rise = sync_q & ~sync_prev & {8{enable}}; // dropped while disabled.

    // lowest pending index goes first.
    always_comb begin
        sel_idx = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (pending[i]) begin
                sel_idx = 3'(i);
            end
        end
    end

    assign have     = |pending;
    assign sel_mask = have ? (8'b1 << sel_idx) : 8'b0;

    // ***********************************************************************
    // pending edges and credits
    // ***********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
            credits <= CW'(CMD_CREDITS);
        end else begin
            pending <= (pending & ~sel_mask) | rise; // no credit means dropped.
            case ({cmd_valid, cmd_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign cmd_valid = have && (credits != '0);
    assign cmd_arg   = colour_idx_t'(sel_idx[1:0]);

    always_comb begin
        case (sel_idx)
            3'd4:    cmd_op = FILL;
            3'd5:    cmd_op = DISP_ON;
            3'd6:    cmd_op = DISP_OFF;
            3'd7:    cmd_op = CLEAR;
            default: cmd_op = SET_COLOUR; // buttons 0 to 3.
        endcase
    end

endmodule

// ==== src/tft_execute.sv ====
`timescale 1ns/1ns
`include "tft_params.svh"

module tft_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  tft_pkg::cmd_op_t     cmd_op,
    input  tft_pkg::colour_idx_t cmd_arg,
    input  logic                 te,
    input  logic                 byte_credit,
    output logic                 cmd_credit,
    output logic                 byte_valid,
    output tft_pkg::tft_byte_t   byte_data,
    output logic                 byte_dc,
    output tft_pkg::exec_state_t state,
    output tft_pkg::colour_idx_t colour,
    output logic                 fill_done,
    output logic                 lcd_rst_n
);

    import tft_pkg::*;

    localparam int QDEPTH       = `TFT_CMD_CREDITS;
    localparam int QW           = $clog2(QDEPTH);
    localparam int BYTE_CREDITS = `TFT_BYTE_CREDITS;
    localparam int BCW          = $clog2(BYTE_CREDITS + 1);
    localparam logic [15:0] LAST_PIX = 16'(`TFT_FILL_PIXELS - 1);

    localparam lcd_cmd_t LCD_SWRESET = 8'h01;
    localparam lcd_cmd_t LCD_SLPOUT  = 8'h11;
    localparam lcd_cmd_t LCD_COLMOD  = 8'h3A;
    localparam lcd_cmd_t LCD_RGB565  = 8'h55;
    localparam lcd_cmd_t LCD_DISPON  = 8'h29;
    localparam lcd_cmd_t LCD_DISPOFF = 8'h28;
    localparam lcd_cmd_t LCD_RAMWR   = 8'h2C;

    cmd_op_t       q_op  [QDEPTH];
    colour_idx_t   q_arg [QDEPTH];
    logic [QW:0]   q_wr;
    logic [QW:0]   q_rd;
    logic          q_empty;
    logic          pop;
    cmd_op_t       head_op;
    colour_idx_t   head_arg;
    logic          te_meta;
    logic          te_sync;
    logic [BCW-1:0] byte_cnt;
    logic          want_send;
    logic          send;
    logic [2:0]    init_cnt;
    logic          fill_active;
    logic [15:0]   pix_cnt;
    logic          pix_half;
    pixel_t        pix_value;
    lcd_cmd_t      cmd_byte;
    tft_byte_t     next_byte;
    logic          next_dc;

    function automatic pixel_t colour_rgb(input colour_idx_t idx);
        case (idx)
            2'd0:    return 16'hF800;
            2'd1:    return 16'h07E0;
            2'd2:    return 16'h001F;
            default: return 16'hFFFF;
        endcase
    endfunction

    // ***********************************************************************
    // command queue
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            q_op[q_wr[QW-1:0]]  <= cmd_op;
            q_arg[q_wr[QW-1:0]] <= cmd_arg;
        end
    end

    assign q_empty  = (q_wr == q_rd);
    assign head_op  = q_op[q_rd[QW-1:0]];
    assign head_arg = q_arg[q_rd[QW-1:0]];
    assign pop      = (state == IDLE) && !q_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_wr       <= '0;
            q_rd       <= '0;
            cmd_credit <= 1'b0;
            te_meta    <= 1'b0;
            te_sync    <= 1'b0;
        end else begin
            if (cmd_valid) q_wr <= q_wr + 1'b1;
            if (pop) q_rd <= q_rd + 1'b1;
            cmd_credit <= pop;  // one credit per pop.
            te_meta    <= te;
            te_sync    <= te_meta;
        end
    end

    // ***********************************************************************
    // byte stream
    // ***********************************************************************

    assign want_send = (state == INIT) || (state == SEND_CMD) || (state == SEND_PIX);
    assign send      = want_send && (byte_cnt != '0);

    always_comb begin
        next_dc   = 1'b0;
        next_byte = '0;
        case (state)
            INIT: begin
                case (init_cnt)
                    3'd0:    next_byte = LCD_SWRESET;
                    3'd1:    next_byte = LCD_SLPOUT;
                    3'd2:    next_byte = LCD_COLMOD;
                    3'd3:    next_byte = LCD_RGB565;
                    default: next_byte = LCD_DISPON;
                endcase
                next_dc = (init_cnt == 3'd3); // format argument is data.
            end
            SEND_CMD: next_byte = cmd_byte;
            SEND_PIX: begin
                next_byte = pix_half ? pix_value[7:0] : pix_value[15:8];
                next_dc   = 1'b1;
            end
            default: next_byte = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (send) begin
            byte_data <= next_byte;
            byte_dc   <= next_dc;
        end
        if (pop) begin
            case (head_op)
                FILL:     pix_value <= colour_rgb(colour);
                CLEAR:    pix_value <= '0; // black.
                DISP_ON:  cmd_byte  <= LCD_DISPON;
                DISP_OFF: cmd_byte  <= LCD_DISPOFF;
                default:  cmd_byte  <= cmd_byte;
            endcase
        end else if (state == WAIT_TE) begin
            cmd_byte <= LCD_RAMWR;
        end
    end

    // ***********************************************************************
    // sequencer
    // ***********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            init_cnt    <= '0;
            colour      <= '0;
            fill_active <= 1'b0;
            pix_cnt     <= '0;
            pix_half    <= 1'b0;
            fill_done   <= 1'b0;
            lcd_rst_n   <= 1'b0;
            byte_valid  <= 1'b0;
            byte_cnt    <= BCW'(BYTE_CREDITS);
        end else begin
            lcd_rst_n  <= 1'b1;
            byte_valid <= send;
            case ({send, byte_credit})
                2'b10:   byte_cnt <= byte_cnt - 1'b1;
                2'b01:   byte_cnt <= byte_cnt + 1'b1;
                default: byte_cnt <= byte_cnt;
            endcase
            case (state)
                INIT: begin
                    if (send) begin
                        init_cnt <= init_cnt + 1'b1;
                        if (init_cnt == 3'd4) state <= IDLE;
                    end
                end
                IDLE: begin
                    if (pop) begin
                        case (head_op)
                            SET_COLOUR: colour <= head_arg;
                            FILL, CLEAR: begin
                                fill_active <= 1'b1;
                                state       <= WAIT_TE;
                            end
                            default: begin
                                fill_active <= 1'b0;
                                state       <= SEND_CMD;
                            end
                        endcase
                    end
                end
                WAIT_TE: begin
                    if (te_sync) state <= SEND_CMD;
                end
                SEND_CMD: begin
                    pix_cnt  <= '0;
                    pix_half <= 1'b0;
                    if (send) state <= fill_active ? SEND_PIX : IDLE;
                end
                SEND_PIX: begin
                    if (send) begin
                        pix_half <= ~pix_half;
                        if (pix_half && pix_cnt == LAST_PIX) begin
                            state       <= IDLE;
                            fill_active <= 1'b0;
                            fill_done   <= ~fill_done; // one toggle per fill.
                        end else if (pix_half) begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/tft_bus_writer.sv ====
`timescale 1ns/1ns
`include "tft_params.svh"

module tft_bus_writer (
    input  logic               clk,
    input  logic               rst,
    input  logic               byte_valid,
    input  tft_pkg::tft_byte_t byte_data,
    input  logic               byte_dc,
    output logic               byte_credit,
    output logic               cs_n,
    output logic               dc,
    output logic               wr_n,
    output tft_pkg::tft_byte_t data
);

    import tft_pkg::*;

    localparam int DEPTH = `TFT_BYTE_CREDITS;
    localparam int PW    = $clog2(DEPTH);

    tft_byte_t   buf_data [DEPTH];
    logic        buf_dc   [DEPTH];
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        buf_empty;
    logic        load;

    assign buf_empty = (wr_ptr == rd_ptr);
    assign load      = wr_n && !buf_empty; // start a write cycle.

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            buf_data[wr_ptr[PW-1:0]] <= byte_data;
            buf_dc[wr_ptr[PW-1:0]]   <= byte_dc;
        end
        if (load) begin
            data <= buf_data[rd_ptr[PW-1:0]];
            dc   <= buf_dc[rd_ptr[PW-1:0]];
        end
    end

    // ***********************************************************************
    // write strobe, one cycle low then one high
    // ***********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            cs_n        <= 1'b1;
            wr_n        <= 1'b1;
            byte_credit <= 1'b0;
        end else begin
            if (byte_valid) wr_ptr <= wr_ptr + 1'b1;
            byte_credit <= ~wr_n;       // returned in the high phase.
            if (!wr_n) begin
                wr_n <= 1'b1;
            end else if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
                wr_n   <= 1'b0;
                cs_n   <= 1'b0;
            end else begin
                cs_n   <= 1'b1;         // buffer drained.
            end
        end
    end

endmodule

// ==== src/ecp5wrapper.sv ====
`timescale 1ns/1ns

module ecp5wrapper (
    input  logic clk,
    input  logic rst,

    input  logic switch4,

    input  logic J39_b15,
    input  logic J39_c15,
    input  logic J39_b20,
    input  logic J39_e11,

    input  logic J39_b10,
    input  logic J39_a14,
    input  logic J39_d13,
    input  logic J39_e12,

    input  logic J40_m3,
    output logic J40_a15,
    output logic J40_h2,
    output logic J40_j4,
    output logic J40_j3,
    output logic J40_l4,
    output logic J40_m4,
    output logic J40_n4,
    output logic J40_p5,
    output logic J40_n5,
    output logic J40_l5,
    output logic J40_k3,
    output logic J40_j5,

    output tft_pkg::exec_state_t tftstate,
    output logic [2:0]           leds,
    output logic                 test
);

    import tft_pkg::*;

    logic        sys_reset;
    logic [7:0]  buttons;
    logic        cmd_valid;
    cmd_op_t     cmd_op;
    colour_idx_t cmd_arg;
    logic        cmd_credit;
    logic        byte_valid;
    tft_byte_t   byte_data;
    logic        byte_dc;
    logic        byte_credit;
    colour_idx_t colour;
    tft_byte_t   bus_data;

    // colours 0 to 3, then fill, on, off, clear.
    assign buttons = {J39_e12, J39_d13, J39_a14, J39_b10,
                      J39_e11, J39_b20, J39_c15, J39_b15};

    assign leds = (colour == 2'd3) ? 3'b111 : (3'b001 << colour); // white lights all.

    assign J40_l4 = bus_data[0];
    assign J40_m4 = bus_data[1];
    assign J40_n4 = bus_data[2];
    assign J40_p5 = bus_data[3];
    assign J40_n5 = bus_data[4];
    assign J40_l5 = bus_data[5];
    assign J40_k3 = bus_data[6];
    assign J40_j5 = bus_data[7];

    reset_on_start ros (
        .clk    (clk),
        .manual (rst),
        .reset  (sys_reset)
    );

    key_decode key_decode_inst (
        .clk        (clk),
        .rst        (sys_reset),
        .enable     (switch4),
        .buttons    (buttons),
        .cmd_credit (cmd_credit),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg)
    );

    tft_execute tft_execute_inst (
        .clk         (clk),
        .rst         (sys_reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_arg     (cmd_arg),
        .te          (J40_m3),
        .byte_credit (byte_credit),
        .cmd_credit  (cmd_credit),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_dc     (byte_dc),
        .state       (tftstate),
        .colour      (colour),
        .fill_done   (test),
        .lcd_rst_n   (J40_a15)
    );

    tft_bus_writer tft_bus_writer_inst (
        .clk         (clk),
        .rst         (sys_reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_dc     (byte_dc),
        .byte_credit (byte_credit),
        .cs_n        (J40_h2),
        .dc          (J40_j4),
        .wr_n        (J40_j3),
        .data        (bus_data)
    );

endmodule

// ==== dv/tb_ecp5wrapper.sv ====
`timescale 1ns/1ns
`include "tft_params.svh"

module tb_ecp5wrapper;

    import tft_pkg::*;

    localparam int MAX_RECORDS = 64;
    localparam int FILL_PIXELS = `TFT_FILL_PIXELS;

    logic        clk = 1'b0;
    logic        rst;
    logic        switch4;
    logic [7:0]  btn;
    logic        te;
    logic        lcd_rst_n;
    logic        cs_n;
    logic        dc;
    logic        wr_n;
    logic [7:0]  bus_data;
    exec_state_t tftstate;
    logic [2:0]  leds;
    logic        test;

    logic [31:0] records [MAX_RECORDS];
    int          n_records;
    logic        exp_dc [$];
    logic [7:0]  exp_data [$];
    logic [31:0] press_word [$];
    int          press_need [$];       // expected bytes due before each press.
    int          seen_count = 0;
    logic        waiting_te = 1'b0;
    logic        prev_wr_n = 1'b1;
    logic [7:0]  cap_data;
    logic        cap_dc;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rng_state = 32'd21338;
    logic [1:0]  exp_colour = 2'd0;
    logic        exp_test = 1'b0;

    always #50 clk = ~clk;

    ecp5wrapper ecp5wrapper_inst (
        .clk      (clk),
        .rst      (rst),
        .switch4  (switch4),
        .J39_b15  (btn[0]),
        .J39_c15  (btn[1]),
        .J39_b20  (btn[2]),
        .J39_e11  (btn[3]),
        .J39_b10  (btn[4]),
        .J39_a14  (btn[5]),
        .J39_d13  (btn[6]),
        .J39_e12  (btn[7]),
        .J40_m3   (te),
        .J40_a15  (lcd_rst_n),
        .J40_h2   (cs_n),
        .J40_j4   (dc),
        .J40_j3   (wr_n),
        .J40_l4   (bus_data[0]),
        .J40_m4   (bus_data[1]),
        .J40_n4   (bus_data[2]),
        .J40_p5   (bus_data[3]),
        .J40_n5   (bus_data[4]),
        .J40_l5   (bus_data[5]),
        .J40_k3   (bus_data[6]),
        .J40_j5   (bus_data[7]),
        .tftstate (tftstate),
        .leds     (leds),
        .test     (test)
    );

    // ***********************************************************************
    // helpers
    // ***********************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [2:0] colour_leds(input logic [1:0] idx);
        case (idx)
            2'd0:    return 3'b001;  // red.
            2'd1:    return 3'b010;  // green.
            2'd2:    return 3'b100;  // blue.
            default: return 3'b111;  // white lights all.
        endcase
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected,
                 actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic load_records();
        logic [31:0] rec;
        for (int i = 0; i < MAX_RECORDS; i++) begin
            records[i] = '0;
        end
        $readmemh("dv/tft_testdata.txt", records);
        n_records = 0;
        while (n_records < MAX_RECORDS && records[n_records][31:28] != 4'h0) begin
            rec = records[n_records];
            case (rec[31:28])
                4'h1: begin
                    press_word.push_back(rec);
                    press_need.push_back(exp_data.size());
                end
                4'h2: begin
                    exp_dc.push_back(rec[8]);
                    exp_data.push_back(rec[7:0]);
                end
                4'h3: begin
                    for (int p = 0; p < FILL_PIXELS; p++) begin
                        exp_dc.push_back(1'b1);
                        exp_data.push_back(rec[15:8]); // high byte first.
                        exp_dc.push_back(1'b1);
                        exp_data.push_back(rec[7:0]);
                    end
                end
                default: report_problem("unknown record kind in the test data file");
            endcase
            n_records++;
        end
    endtask

    task automatic press_button(input logic [2:0] idx);
        btn[idx] = 1'b1;
        repeat (4) @(negedge clk);
        btn[idx] = 1'b0;
    endtask

    task automatic check_state();
        assert (lcd_rst_n == 1'b1) else report_mismatch("J40_a15", 1, int'(lcd_rst_n));
        assert (tftstate == IDLE)
            else report_mismatch("tftstate", int'(IDLE), int'(tftstate));
        assert (leds == colour_leds(exp_colour))
            else report_mismatch("leds", int'(colour_leds(exp_colour)), int'(leds));
        assert (test == exp_test) else report_mismatch("test", int'(exp_test), int'(test));
    endtask

    // ***********************************************************************
    // bus monitor, sampled on the falling edge
    // ***********************************************************************

    always @(negedge clk) begin
        if (!wr_n) begin
            assert (!cs_n) else report_problem("chip select high during a write strobe");
            assert (prev_wr_n) else report_problem("write strobe low for more than one cycle");
            cap_data = bus_data;
            cap_dc   = dc;
        end else if (!prev_wr_n) begin
            assert (!cs_n) else report_problem("chip select high in the write high phase");
            assert (bus_data == cap_data && dc == cap_dc)
                else report_problem("data or dc changed during a write cycle");
            assert (!waiting_te) else report_problem("bus byte seen before te was pulsed");
            assert (seen_count < exp_data.size())
                else report_problem("bus byte seen with no expected byte pending");
            assert (cap_dc == exp_dc[seen_count])
                else report_mismatch("J40_j4", int'(exp_dc[seen_count]), int'(cap_dc));
            assert (cap_data == exp_data[seen_count])
                else report_mismatch("bus_data", int'(exp_data[seen_count]), int'(cap_data));
            seen_count++;
        end
        prev_wr_n = wr_n;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            report_problem("timeout, expected bus bytes never arrived");
        end
    end

    // ***********************************************************************
    // stimulus
    // ***********************************************************************

    initial begin
        logic [31:0] word;
        int          gap;
        rst     = 1'b1;
        switch4 = 1'b0;
        btn     = '0;
        te      = 1'b0;
        load_records();
        limit = n_records * 200 + 500;
        repeat (2) begin
            @(negedge clk);
            assert (lcd_rst_n == 1'b0) else report_mismatch("J40_a15", 0, int'(lcd_rst_n));
            assert (cs_n == 1'b1) else report_mismatch("J40_h2", 1, int'(cs_n));
            assert (wr_n == 1'b1) else report_mismatch("J40_j3", 1, int'(wr_n));
            assert (test == 1'b0) else report_mismatch("test", 0, int'(test));
            assert (leds == 3'b001) else report_mismatch("leds", 1, int'(leds));
        end
        rst = 1'b0;
        for (int k = 0; k < press_word.size(); k++) begin
            word = press_word[k];
            while (seen_count < press_need[k]) @(negedge clk);
            rng_state = xorshift32(rng_state);
            gap       = 20 + int'(rng_state % 32'd41);
            switch4   = word[20];
            repeat (gap) @(negedge clk);
            check_state();
            if (word[16]) waiting_te = 1'b1;
            press_button(word[26:24]);
            if (word[20] && word[26:24] < 3'd4) exp_colour = word[25:24];
            if (word[20] && (word[26:24] == 3'd4 || word[26:24] == 3'd7)) exp_test = ~exp_test;
            if (word[16]) begin
                while (tftstate != WAIT_TE) @(negedge clk);
                repeat (10) @(negedge clk); // panel not ready yet.
                te         = 1'b1;
                waiting_te = 1'b0;
                repeat (3) @(negedge clk);
                te         = 1'b0;
            end
        end
        while (seen_count < exp_data.size()) @(negedge clk);
        repeat (100) @(negedge clk);        // catch stray bytes.
        check_state();
        if (seen_count == exp_data.size()) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_problem("bus byte count differs from the expected stream");
        end
    end

endmodule

// ==== dv/tft_testdata.txt ====
// kind in bits 31:28. 1 is a press: button 26:24, switch4 20, te pulse 16.
// 2 is a bus byte: dc 8, data 7:0. 3 is a fill run: rgb565 15:0 per pixel.
// init sequence after reset
20000001 20000011 2000003A 20000155 20000029
// red then fill
10100000
14110000
2000002C 3000F800
// green then fill
11100000
14110000
2000002C 300007E0
// blue then fill
12100000
14110000
2000002C 3000001F
// white then fill
13100000
14110000
2000002C 3000FFFF
// display off, display on
16100000
20000028
15100000
20000029
// disabled presses, no bus bytes
11000000
14000000
// clear writes black
17110000
2000002C 30000000

// ==== verilog.f ====
+incdir+src
src/tft_pkg.sv
src/reset_on_start.sv
src/key_decode.sv
src/tft_execute.sv
src/tft_bus_writer.sv
src/ecp5wrapper.sv
dv/tb_ecp5wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compiles the testbench with verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -f verilog.f --top-module tb_ecp5wrapper \
    --Mdir obj_dir -o tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
